// ==== source/fe_mem_pkg.sv ====
`default_nettype none

package fe_mem_pkg;

   localparam int vaddr_width_gp = 32;
   localparam int page_offset_width_gp = 12;
   localparam int vtag_width_gp = 20;
   localparam int ptag_width_gp = 20;
   localparam int paddr_width_gp = ptag_width_gp + page_offset_width_gp;

   localparam int instr_width_gp = 32;
   localparam int block_width_gp = 128;
   localparam int beats_per_block_gp = 4;

   // byte offset inside a block and the untranslated block index above it
   localparam int block_offset_width_gp = $clog2(block_width_gp / 8);
   localparam int block_index_width_gp = page_offset_width_gp - block_offset_width_gp;

   // physical memory ends at 2 GiB, so any ptag from here up is an access fault
   localparam logic [ptag_width_gp-1:0] mem_limit_ptag_gp = 20'h80000;

   typedef enum logic [1:0] {
      e_op_fetch         = 2'd0,
      e_op_tlb_fill      = 2'd1,
      e_op_tlb_fence     = 2'd2,
      e_op_icache_fence  = 2'd3
   } fe_op_e;

   typedef enum logic [1:0] {
      e_priv_u = 2'd0,
      e_priv_s = 2'd1,
      e_priv_m = 2'd3
   } priv_e;

   typedef struct packed {
      logic [ptag_width_gp-1:0] ptag;
      logic                     u;
      logic                     x;
   } tlb_entry_s;

   // both operand views share the 62 bits below the op field
   localparam int cmd_operand_width_gp = 62;

   typedef struct packed {
      logic [vaddr_width_gp-1:0]                      vaddr;
      logic [cmd_operand_width_gp-vaddr_width_gp-1:0] pad;
   } fetch_operands_s;

   typedef struct packed {
      logic [vtag_width_gp-1:0] vtag;
      tlb_entry_s               entry;
      logic [cmd_operand_width_gp-vtag_width_gp-$bits(tlb_entry_s)-1:0] pad;
   } fill_operands_s;

   typedef union packed {
      fetch_operands_s fetch;
      fill_operands_s  fill;
   } cmd_operands_u;

   typedef struct packed {
      fe_op_e        op;
      cmd_operands_u operands;
   } mem_cmd_s;

   typedef struct packed {
      logic                      instr_access_fault;
      logic                      instr_page_fault;
      logic                      itlb_miss;
      logic                      icache_miss;
      logic [instr_width_gp-1:0] data;
   } mem_resp_s;

   // physical block address, ptag on top of the in-page block index
   typedef struct packed {
      logic [ptag_width_gp-1:0]        ptag;
      logic [block_index_width_gp-1:0] index;
   } cache_req_s;

   typedef enum logic [1:0] {
      e_fill_idle  = 2'd0,
      e_fill_req   = 2'd1,
      e_fill_wait  = 2'd2,
      e_fill_write = 2'd3
   } fill_state_e;

endpackage

`default_nettype wire

// ==== source/fe_itlb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_itlb
   import fe_mem_pkg::*;
#(
   parameter int itlb_els_p = 8
) (
   input  wire logic                     clk_i,
   input  wire logic                     reset_i,
   input  wire logic                     flush_i,
   input  wire logic                     v_i,
   input  wire logic                     w_i,
   input  wire logic [vtag_width_gp-1:0] vtag_i,
   input  wire tlb_entry_s               entry_i,
   output logic                          v_o,
   output logic                          miss_v_o,
   output tlb_entry_s                    entry_o
);

   localparam int ptr_width_lp = (itlb_els_p > 1) ? $clog2(itlb_els_p) : 1;

   logic [vtag_width_gp-1:0] vtag_mem [itlb_els_p];
   tlb_entry_s               entry_mem [itlb_els_p];
   logic [itlb_els_p-1:0]    valid_r;

   logic [ptr_width_lp-1:0] victim_r;
   logic [ptr_width_lp-1:0] hit_idx;
   logic [ptr_width_lp-1:0] wr_idx;
   logic                    hit;
   logic                    write_v;
   logic                    read_v;
   logic                    rd_v_r;
   logic                    hit_r;

   // fully associative match over every valid entry
   always_comb begin
      hit = 1'b0;
      hit_idx = '0;
      for (int i = 0; i < itlb_els_p; i++) begin
         if (valid_r[i] && (vtag_mem[i] == vtag_i)) begin
            hit = 1'b1;
            hit_idx = ptr_width_lp'(i);
         end
      end
   end

   assign write_v = v_i & w_i;
   assign read_v = v_i & ~w_i;

   // a refill of a vtag already present overwrites it in place
   assign wr_idx = hit ? hit_idx : victim_r;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r <= '0;
         victim_r <= '0;
         rd_v_r <= 1'b0;
      end else begin
         rd_v_r <= read_v;
         if (flush_i) begin
            valid_r <= '0;
         end else if (write_v) begin
            valid_r[wr_idx] <= 1'b1;
         end
         if (write_v && !hit) begin
            victim_r <= (victim_r == ptr_width_lp'(itlb_els_p - 1)) ? '0 : victim_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (write_v) begin
         vtag_mem[wr_idx] <= vtag_i;
         entry_mem[wr_idx] <= entry_i;
      end
      if (read_v) begin
         hit_r <= hit;
         entry_o <= entry_mem[hit_idx];
      end
   end

   assign v_o = rd_v_r & hit_r;
   assign miss_v_o = rd_v_r & ~hit_r;

endmodule

`default_nettype wire

// ==== source/fe_icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_icache
   import fe_mem_pkg::*;
#(
   parameter int icache_sets_p = 64
) (
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire logic [vaddr_width_gp-1:0] vaddr_i,
   input  wire logic                      fence_i,
   input  wire logic                      v_i,
   input  wire logic [ptag_width_gp-1:0]  ptag_i,
   input  wire logic                      ptag_v_i,
   input  wire logic                      poison_i,
   input  wire logic                      block_v_i,
   input  wire logic [block_width_gp-1:0] block_i,
   output logic                           ready_o,
   output logic [instr_width_gp-1:0]      data_o,
   output logic                           data_v_o,
   output cache_req_s                     cache_req_o,
   output logic                           cache_req_v_o
);

   localparam int set_width_lp = $clog2(icache_sets_p);
   localparam int word_width_lp = $clog2(beats_per_block_gp);

   // the tag keeps the whole block address because the set drops the top of the in-page index
   logic [block_width_gp-1:0] data_mem [icache_sets_p];
   cache_req_s                tag_mem [icache_sets_p];
   logic [icache_sets_p-1:0]  valid_r;

   logic                            fetch_v;
   logic                            fence_v;
   logic [block_index_width_gp-1:0] index_s0;
   logic [set_width_lp-1:0]         set_s0;
   logic [word_width_lp-1:0]        word_s0;
   logic [set_width_lp-1:0]         fill_set;

   // stage 1 state
   logic                            v_tl_r;
   logic [block_index_width_gp-1:0] index_r;
   logic [word_width_lp-1:0]        word_r;
   logic [block_width_gp-1:0]       block_r;
   cache_req_s                      tag_r;
   logic                            valid_bit_r;
   logic                            hit_tl;
   logic                            miss_tl;
   logic                            miss_pending_r;

   assign fetch_v = v_i & ~fence_i;
   assign fence_v = v_i & fence_i;

   assign index_s0 = vaddr_i[page_offset_width_gp-1:block_offset_width_gp];
   assign set_s0 = index_s0[set_width_lp-1:0];
   assign word_s0 = vaddr_i[block_offset_width_gp-1 -: word_width_lp];

   // the fill always lands in the set recorded with the miss request
   assign fill_set = cache_req_o.index[set_width_lp-1:0];

   // stage 0 reads the arrays into registers
   always_ff @(posedge clk_i) begin
      if (fetch_v) begin
         index_r <= index_s0;
         word_r <= word_s0;
         block_r <= data_mem[set_s0];
         tag_r <= tag_mem[set_s0];
         valid_bit_r <= valid_r[set_s0];
      end
   end

   assign hit_tl = v_tl_r & ptag_v_i & valid_bit_r & (tag_r.ptag == ptag_i)
                 & (tag_r.index == index_r);

   // only one miss is tracked, a second one just reports a miss and is retried
   assign miss_tl = v_tl_r & ptag_v_i & ~hit_tl & ~poison_i & ~miss_pending_r;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         v_tl_r <= 1'b0;
         data_v_o <= 1'b0;
         cache_req_v_o <= 1'b0;
         miss_pending_r <= 1'b0;
         valid_r <= '0;
      end else begin
         v_tl_r <= fetch_v;
         data_v_o <= hit_tl;
         cache_req_v_o <= miss_tl;
         if (miss_tl) begin
            miss_pending_r <= 1'b1;
         end else if (block_v_i) begin
            miss_pending_r <= 1'b0;
         end
         if (fence_v) begin
            valid_r <= '0;
         end else if (block_v_i) begin
            valid_r[fill_set] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      data_o <= block_r[word_r*instr_width_gp +: instr_width_gp];
      if (miss_tl) begin
         cache_req_o <= '{ptag: ptag_i, index: index_r};
      end
   end

   always_ff @(posedge clk_i) begin
      if (block_v_i) begin
         data_mem[fill_set] <= block_i;
         tag_mem[fill_set] <= cache_req_o;
      end
   end

   // ready stays low from the miss until the cycle after the block is written
   assign ready_o = ~miss_pending_r;

endmodule

`default_nettype wire

// ==== source/fe_fill_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_fill_engine
   import fe_mem_pkg::*;
(
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire cache_req_s                cache_req_i,
   input  wire logic                      cache_req_v_i,
   input  wire logic                      mem_rd_data_v_i,
   input  wire logic [instr_width_gp-1:0] mem_rd_data_i,
   output logic                           mem_rd_v_o,
   output logic [paddr_width_gp-1:0]      mem_rd_addr_o,
   output logic                           block_v_o,
   output logic [block_width_gp-1:0]      block_o
);

   localparam int beat_width_lp = $clog2(beats_per_block_gp);
   localparam int byte_width_lp = block_offset_width_gp - beat_width_lp;

   fill_state_e              state_r;
   logic [beat_width_lp-1:0] beat_r;
   cache_req_s               req_r;
   logic                     last_beat;

   assign last_beat = (beat_r == beat_width_lp'(beats_per_block_gp - 1));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_r <= e_fill_idle;
         beat_r <= '0;
      end else begin
         case (state_r)
            e_fill_idle: begin
               if (cache_req_v_i) begin
                  state_r <= e_fill_req;
                  beat_r <= '0;
               end
            end
            e_fill_req: state_r <= e_fill_wait;
            e_fill_wait: begin
               if (mem_rd_data_v_i) begin
                  if (last_beat) begin
                     state_r <= e_fill_write;
                  end else begin
                     beat_r <= beat_r + 1'b1;
                     state_r <= e_fill_req;
                  end
               end
            end
            e_fill_write: state_r <= e_fill_idle;
            default: state_r <= e_fill_idle;
         endcase
      end
   end

   // beats arrive lowest word first, so shifting down leaves word 0 at the bottom
   always_ff @(posedge clk_i) begin
      if ((state_r == e_fill_idle) && cache_req_v_i) begin
         req_r <= cache_req_i;
      end
      if ((state_r == e_fill_wait) && mem_rd_data_v_i) begin
         block_o <= {mem_rd_data_i, block_o[block_width_gp-1:instr_width_gp]};
      end
   end

   assign mem_rd_v_o = (state_r == e_fill_req);
   // byte address of the current word
   assign mem_rd_addr_o = {req_r, beat_r, {byte_width_lp{1'b0}}};
   assign block_v_o = (state_r == e_fill_write);

endmodule

`default_nettype wire

// ==== source/fe_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_mem
   import fe_mem_pkg::*;
#(
   parameter int itlb_els_p = 8,
   parameter int icache_sets_p = 64
) (
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire mem_cmd_s                  mem_cmd_i,
   input  wire logic                      mem_cmd_v_i,
   output logic                           mem_cmd_yumi_o,
   input  wire priv_e                     mem_priv_i,
   input  wire logic                      mem_translation_en_i,
   input  wire logic                      mem_poison_i,
   output mem_resp_s                      mem_resp_o,
   output logic                           mem_resp_v_o,
   output cache_req_s                     cache_req_o,
   output logic                           cache_req_v_o,
   input  wire logic                      block_v_i,
   input  wire logic [block_width_gp-1:0] block_i
);

   logic fetch_ready;
   logic itlb_fence_v;
   logic itlb_fill_v;
   logic fetch_v;
   logic fencei_v;

   assign itlb_fence_v = mem_cmd_v_i & (mem_cmd_i.op == e_op_tlb_fence);
   assign itlb_fill_v = mem_cmd_v_i & (mem_cmd_i.op == e_op_tlb_fill);
   assign fetch_v = fetch_ready & mem_cmd_v_i & (mem_cmd_i.op == e_op_fetch);
   assign fencei_v = fetch_ready & mem_cmd_v_i & (mem_cmd_i.op == e_op_icache_fence);

   assign mem_cmd_yumi_o = itlb_fence_v | itlb_fill_v | fetch_v | fencei_v;

   logic [vtag_width_gp-1:0] fetch_vtag;
   logic [vtag_width_gp-1:0] vtag_r;
   logic                     itlb_v_lo;
   logic                     itlb_miss_lo;
   tlb_entry_s               itlb_entry_lo;

   // the fill vtag sits in the same command bits as the fetch vtag
   assign fetch_vtag = mem_cmd_i.operands.fetch.vaddr[vaddr_width_gp-1 -: vtag_width_gp];

   fe_itlb #(
      .itlb_els_p(itlb_els_p)
   ) itlb (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .flush_i(itlb_fence_v),
      .v_i(itlb_fill_v | (fetch_v & mem_translation_en_i)),
      .w_i(itlb_fill_v),
      .vtag_i(fetch_vtag),
      .entry_i(mem_cmd_i.operands.fill.entry),
      .v_o(itlb_v_lo),
      .miss_v_o(itlb_miss_lo),
      .entry_o(itlb_entry_lo)
   );

   always_ff @(posedge clk_i) begin
      if (fetch_v) begin
         vtag_r <= fetch_vtag;
      end
   end

   logic                     fetch_v_r;
   logic                     resp_v_r;
   logic [ptag_width_gp-1:0] ptag_li;
   logic                     ptag_v_li;
   logic                     access_fault_v;
   logic                     page_fault_v;
   logic                     priv_fault;

   // with translation off the vtag is used as the ptag
   assign ptag_li = mem_translation_en_i ? itlb_entry_lo.ptag : vtag_r;
   assign ptag_v_li = mem_translation_en_i ? itlb_v_lo : fetch_v_r;

   assign priv_fault = ((mem_priv_i == e_priv_s) & itlb_entry_lo.u)
                     | ((mem_priv_i == e_priv_u) & ~itlb_entry_lo.u);
   assign access_fault_v = ptag_v_li & (ptag_li >= mem_limit_ptag_gp);
   assign page_fault_v = fetch_v_r & mem_translation_en_i & itlb_v_lo
                       & (priv_fault | ~itlb_entry_lo.x);

   logic [instr_width_gp-1:0] icache_data_lo;
   logic                      icache_data_v_lo;

   fe_icache #(
      .icache_sets_p(icache_sets_p)
   ) icache (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .vaddr_i(mem_cmd_i.operands.fetch.vaddr),
      .fence_i(fencei_v),
      .v_i(fetch_v | fencei_v),
      .ptag_i(ptag_li),
      .ptag_v_i(ptag_v_li),
      .poison_i(mem_poison_i | access_fault_v | page_fault_v | itlb_miss_lo),
      .block_v_i(block_v_i),
      .block_i(block_i),
      .ready_o(fetch_ready),
      .data_o(icache_data_lo),
      .data_v_o(icache_data_v_lo),
      .cache_req_o(cache_req_o),
      .cache_req_v_o(cache_req_v_o)
   );

   logic itlb_miss_r;
   logic access_fault_r;
   logic page_fault_r;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fetch_v_r <= 1'b0;
         resp_v_r <= 1'b0;
         itlb_miss_r <= 1'b0;
         access_fault_r <= 1'b0;
         page_fault_r <= 1'b0;
      end else begin
         fetch_v_r <= fetch_v;
         resp_v_r <= fetch_v_r & ~mem_poison_i;
         itlb_miss_r <= itlb_miss_lo & ~mem_poison_i;
         access_fault_r <= access_fault_v & ~mem_poison_i;
         page_fault_r <= page_fault_v & ~mem_poison_i;
      end
   end

   assign mem_resp_v_o = resp_v_r;
   assign mem_resp_o = '{instr_access_fault: access_fault_r,
                         instr_page_fault: page_fault_r,
                         itlb_miss: itlb_miss_r,
                         icache_miss: resp_v_r & ~icache_data_v_lo,
                         data: icache_data_lo};

endmodule

`default_nettype wire

// ==== source/fe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_top
   import fe_mem_pkg::*;
#(
   parameter int itlb_els_p = 8,
   parameter int icache_sets_p = 64
) (
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire mem_cmd_s                  mem_cmd_i,
   input  wire logic                      mem_cmd_v_i,
   output logic                           mem_cmd_yumi_o,
   input  wire priv_e                     mem_priv_i,
   input  wire logic                      mem_translation_en_i,
   input  wire logic                      mem_poison_i,
   output mem_resp_s                      mem_resp_o,
   output logic                           mem_resp_v_o,
   output logic                           mem_rd_v_o,
   output logic [paddr_width_gp-1:0]      mem_rd_addr_o,
   input  wire logic                      mem_rd_data_v_i,
   input  wire logic [instr_width_gp-1:0] mem_rd_data_i
);

   cache_req_s                cache_req;
   logic                      cache_req_v;
   logic                      block_v;
   logic [block_width_gp-1:0] block;

   fe_mem #(
      .itlb_els_p(itlb_els_p),
      .icache_sets_p(icache_sets_p)
   ) mem (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .mem_cmd_i(mem_cmd_i),
      .mem_cmd_v_i(mem_cmd_v_i),
      .mem_cmd_yumi_o(mem_cmd_yumi_o),
      .mem_priv_i(mem_priv_i),
      .mem_translation_en_i(mem_translation_en_i),
      .mem_poison_i(mem_poison_i),
      .mem_resp_o(mem_resp_o),
      .mem_resp_v_o(mem_resp_v_o),
      .cache_req_o(cache_req),
      .cache_req_v_o(cache_req_v),
      .block_v_i(block_v),
      .block_i(block)
   );

   // miss requests go out as four single-word reads
   fe_fill_engine fill (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .cache_req_i(cache_req),
      .cache_req_v_i(cache_req_v),
      .mem_rd_data_v_i(mem_rd_data_v_i),
      .mem_rd_data_i(mem_rd_data_i),
      .mem_rd_v_o(mem_rd_v_o),
      .mem_rd_addr_o(mem_rd_addr_o),
      .block_v_o(block_v),
      .block_o(block)
   );

endmodule

`default_nettype wire

// ==== verif/fe_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_mem_model
   import fe_mem_pkg::*;
#(
   parameter int latency_p = 3
) (
   input  wire logic                      clk_i,
   input  wire logic                      reset_i,
   input  wire logic                      rd_v_i,
   input  wire logic [paddr_width_gp-1:0] rd_addr_i,
   output logic                           rd_data_v_o,
   output logic [instr_width_gp-1:0]      rd_data_o
);

   logic [latency_p-1:0]      v_pipe_r = '0;
   logic [paddr_width_gp-1:0] addr_r = '0;

   // the fill engine keeps one beat outstanding, so a single address register holds it
   always @(posedge clk_i) begin
      if (reset_i) begin
         v_pipe_r <= '0;
      end else begin
         v_pipe_r <= {v_pipe_r[latency_p-2:0], rd_v_i};
         if (rd_v_i) begin
            addr_r <= rd_addr_i;
         end
      end
   end

   assign rd_data_v_o = v_pipe_r[latency_p-1];

   // every word is its own word address with a fixed pattern on top
   assign rd_data_o = {2'b00, addr_r[paddr_width_gp-1:2]} ^ 32'h5a5a0000;

endmodule

`default_nettype wire

// ==== verif/fe_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fe_top_tb
   import fe_mem_pkg::*;
();

   localparam int fetch_count_lp = 18;
   // four beats of request plus three cycles of latency each, with slack for the block write
   localparam int fill_cycles_lp = 32;
   localparam int timeout_cycles_lp = 16 + fetch_count_lp * (fill_cycles_lp + 12) + 200;

   logic                      clk;
   logic                      reset;
   mem_cmd_s                  mem_cmd;
   logic                      mem_cmd_v;
   logic                      mem_cmd_yumi;
   priv_e                     mem_priv;
   logic                      mem_translation_en;
   logic                      mem_poison;
   mem_resp_s                 mem_resp;
   logic                      mem_resp_v;
   logic                      mem_rd_v;
   logic [paddr_width_gp-1:0] mem_rd_addr;
   logic                      mem_rd_data_v;
   logic [instr_width_gp-1:0] mem_rd_data;

   integer      seed = 32'h3f63;
   int          error_count = 0;
   int          check_count = 0;
   int          rd_count = 0;
   int          cycle_count = 0;
   fill_state_e stuck_state;

   fe_top #(
      .itlb_els_p(8),
      .icache_sets_p(64)
   ) uut (
      .clk_i(clk),
      .reset_i(reset),
      .mem_cmd_i(mem_cmd),
      .mem_cmd_v_i(mem_cmd_v),
      .mem_cmd_yumi_o(mem_cmd_yumi),
      .mem_priv_i(mem_priv),
      .mem_translation_en_i(mem_translation_en),
      .mem_poison_i(mem_poison),
      .mem_resp_o(mem_resp),
      .mem_resp_v_o(mem_resp_v),
      .mem_rd_v_o(mem_rd_v),
      .mem_rd_addr_o(mem_rd_addr),
      .mem_rd_data_v_i(mem_rd_data_v),
      .mem_rd_data_i(mem_rd_data)
   );

   fe_mem_model #(
      .latency_p(3)
   ) memory (
      .clk_i(clk),
      .reset_i(reset),
      .rd_v_i(mem_rd_v),
      .rd_addr_i(mem_rd_addr),
      .rd_data_v_o(mem_rd_data_v),
      .rd_data_o(mem_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(negedge clk) begin
      if (!reset && mem_rd_v) begin
         rd_count++;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= timeout_cycles_lp) begin
         stuck_state = uut.fill.state_r;
         $display("Timeout: run did not finish in %0d cycles, fill engine in %s",
                  cycle_count, stuck_state.name());
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // word address of the byte address with the memory pattern applied
   function automatic logic [instr_width_gp-1:0] expected_word(
      input logic [paddr_width_gp-1:0] paddr);
      return {2'b00, paddr[paddr_width_gp-1:2]} ^ 32'h5a5a0000;
   endfunction

   // flags go access, page, itlb, icache from the top
   function automatic mem_resp_s expected_resp(input logic [3:0] flags,
                                               input logic [instr_width_gp-1:0] data);
      return {flags, data};
   endfunction

   function automatic logic [vaddr_width_gp-1:0] random_legal_addr();
      logic [vaddr_width_gp-1:0] addr;
      addr = $random(seed);
      addr[vaddr_width_gp-1] = 1'b0;
      addr[1:0] = 2'b00;
      return addr;
   endfunction

   task automatic report_error(input string msg);
      error_count++;
      $display("Error at %0t: %s", $time, msg);
   endtask

   task automatic check_resp(input mem_resp_s got, input mem_resp_s exp, input string what);
      logic [3:0] got_flags;
      logic [3:0] exp_flags;
      got_flags = {got.instr_access_fault, got.instr_page_fault, got.itlb_miss, got.icache_miss};
      exp_flags = {exp.instr_access_fault, exp.instr_page_fault, exp.itlb_miss, exp.icache_miss};
      check_count++;
      if (got_flags !== exp_flags) begin
         error_count++;
         $display("Mismatch at %0t: %s flags got %b expected %b", $time, what,
                  got_flags, exp_flags);
      end
   endtask

   task automatic check_instr(input logic [instr_width_gp-1:0] got,
                              input logic [instr_width_gp-1:0] exp, input string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Mismatch at %0t: %s instr got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   // holds the command until yumi and returns 1 ns into the cycle after acceptance
   task automatic send_cmd(input mem_cmd_s cmd);
      mem_cmd = cmd;
      mem_cmd_v = 1'b1;
      @(negedge clk);
      while (!mem_cmd_yumi) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      mem_cmd_v = 1'b0;
      mem_cmd = '0;
   endtask

   task automatic send_op(input fe_op_e op);
      mem_cmd_s cmd;
      cmd = '0;
      cmd.op = op;
      send_cmd(cmd);
   endtask

   task automatic tlb_fill(input logic [vtag_width_gp-1:0] vtag,
                           input logic [ptag_width_gp-1:0] ptag, input logic u, input logic x);
      mem_cmd_s cmd;
      cmd = '0;
      cmd.op = e_op_tlb_fill;
      cmd.operands.fill.vtag = vtag;
      cmd.operands.fill.entry = '{ptag: ptag, u: u, x: x};
      send_cmd(cmd);
   endtask

   // the response is due in the second cycle after acceptance
   task automatic fetch(input logic [vaddr_width_gp-1:0] vaddr, input logic poison,
                        output mem_resp_s resp, output logic got);
      mem_cmd_s cmd;
      cmd = '0;
      cmd.op = e_op_fetch;
      cmd.operands.fetch.vaddr = vaddr;
      send_cmd(cmd);
      mem_poison = poison;
      @(posedge clk);
      #1;
      mem_poison = 1'b0;
      @(negedge clk);
      got = mem_resp_v;
      resp = mem_resp;
      wait_cycles(1);
   endtask

   task automatic fetch_check(input logic [vaddr_width_gp-1:0] vaddr, input mem_resp_s exp,
                              input string what);
      mem_resp_s resp;
      logic      got;
      fetch(vaddr, 1'b0, resp, got);
      if (!got) begin
         report_error({what, ": no response two cycles after the fetch was accepted"});
      end else begin
         check_resp(resp, exp, what);
         if (exp[35:32] == 4'b0000) begin
            check_instr(resp.data, exp.data, what);
         end
      end
   endtask

   task automatic fill_and_check(input logic [vaddr_width_gp-1:0] vaddr,
                                 input logic [paddr_width_gp-1:0] paddr, input string what);
      fetch_check(vaddr, expected_resp(4'b0001, '0), {what, " first fetch"});
      fetch_check(vaddr, expected_resp(4'b0000, expected_word(paddr)), {what, " retry"});
   endtask

   task automatic test_translation_off();
      logic [vaddr_width_gp-1:0] vaddr;
      mem_translation_en = 1'b0;
      mem_priv = e_priv_m;
      vaddr = random_legal_addr();
      fill_and_check(vaddr, vaddr, "translation off");
      fetch_check(vaddr ^ 32'h4, expected_resp(4'b0000, expected_word(vaddr ^ 32'h4)),
                  "neighbour word");
   endtask

   task automatic test_translation_on();
      logic [vaddr_width_gp-1:0] addr;
      logic [vtag_width_gp-1:0]  vtag;
      logic [ptag_width_gp-1:0]  ptag;
      logic [11:0]               off;
      addr = random_legal_addr();
      vtag = addr[31:12];
      off = addr[11:0];
      addr = random_legal_addr();
      ptag = addr[31:12];
      mem_translation_en = 1'b1;
      mem_priv = e_priv_s;
      tlb_fill(vtag, ptag, 1'b0, 1'b1);
      fill_and_check({vtag, off}, {ptag, off}, "translated");
      fetch_check({vtag + 20'd1, off}, expected_resp(4'b0011, '0), "unmapped vtag");
      send_op(e_op_tlb_fence);
      fetch_check({vtag, off}, expected_resp(4'b0011, '0), "after tlb fence");
   endtask

   task automatic test_page_faults();
      logic [vaddr_width_gp-1:0] addr;
      logic [vtag_width_gp-1:0]  vtag;
      logic [ptag_width_gp-1:0]  ptag;
      logic [11:0]               off;
      addr = random_legal_addr();
      vtag = addr[31:12];
      off = addr[11:0];
      addr = random_legal_addr();
      ptag = {2'b00, addr[30:13]};
      mem_translation_en = 1'b1;
      tlb_fill(vtag, ptag, 1'b1, 1'b1);
      tlb_fill(vtag + 20'd1, ptag + 20'd1, 1'b0, 1'b1);
      tlb_fill(vtag + 20'd2, ptag + 20'd2, 1'b0, 1'b0);
      mem_priv = e_priv_s;
      fetch_check({vtag, off}, expected_resp(4'b0101, '0), "S mode on user page");
      mem_priv = e_priv_u;
      fetch_check({vtag + 20'd1, off}, expected_resp(4'b0101, '0), "U mode on supervisor page");
      mem_priv = e_priv_s;
      fetch_check({vtag + 20'd2, off}, expected_resp(4'b0101, '0), "page without x");
      fill_and_check({vtag + 20'd1, off}, {ptag + 20'd1, off}, "legal page");
   endtask

   task automatic test_access_fault();
      logic [vaddr_width_gp-1:0] vaddr;
      int                        reads_before;
      mem_translation_en = 1'b0;
      mem_priv = e_priv_m;
      vaddr = random_legal_addr() | 32'h8000_0000;
      reads_before = rd_count;
      fetch_check(vaddr, expected_resp(4'b1001, '0), "access fault");
      wait_cycles(8);
      if (rd_count != reads_before) begin
         report_error("a memory read started for a fetch with an access fault");
      end
   endtask

   task automatic test_poison();
      logic [vaddr_width_gp-1:0] vaddr;
      mem_resp_s                 resp;
      logic                      got;
      int                        reads_before;
      mem_translation_en = 1'b0;
      vaddr = random_legal_addr();
      reads_before = rd_count;
      fetch(vaddr, 1'b1, resp, got);
      if (got) begin
         report_error("a poisoned fetch produced a response");
      end
      wait_cycles(8);
      if (rd_count != reads_before) begin
         report_error("a memory read started for a poisoned fetch");
      end
   endtask

   task automatic test_icache_fence();
      logic [vaddr_width_gp-1:0] vaddr;
      mem_translation_en = 1'b0;
      vaddr = random_legal_addr();
      fill_and_check(vaddr, vaddr, "before icache fence");
      send_op(e_op_icache_fence);
      fill_and_check(vaddr, vaddr, "after icache fence");
   endtask

   initial begin
      reset = 1'b1;
      mem_cmd = '0;
      mem_cmd_v = 1'b0;
      mem_priv = e_priv_m;
      mem_translation_en = 1'b0;
      mem_poison = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      test_translation_off();
      test_translation_on();
      test_page_faults();
      test_access_fault();
      test_poison();
      test_icache_fence();
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
source/fe_mem_pkg.sv
source/fe_itlb.sv
source/fe_icache.sv
source/fe_fill_engine.sv
source/fe_mem.sv
source/fe_top.sv
verif/fe_mem_model.sv
verif/fe_top_tb.sv
